/* sources.f */
+incdir+include
hw/fpmul_pkg.sv
hw/operand_classify.sv
hw/booth_recode.sv
hw/pp_array.sv
hw/round_normalize.sv
hw/fpmul_unit.sv
bench/fpmul_tb.sv

/* Makefile */
# Verilator build and run of the double precision multiplier testbench
# a failing run ends in $fatal, which gives a nonzero exit status

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module fpmul_tb -Mdir obj_dir
	./obj_dir/Vfpmul_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* bench/fpmul_tb.sv */
//**********************************************************************
// normal products are checked against the simulator's real multiply
// random operands stay in the normal range, their inexact bit is not checked
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fpmul_params.svh"

module fpmul_tb;

	localparam int N_RANDOM = 200;
	localparam int DRAIN_LIMIT = `FPM_LATENCY + 8;    // cycles allowed for the last results
	localparam fpmul_pkg::fp_word_t POS_INF = 64'h7FF0_0000_0000_0000;
	localparam fpmul_pkg::fp_word_t NEG_INF = 64'hFFF0_0000_0000_0000;
	localparam fpmul_pkg::fp_word_t QNAN = 64'h7FF8_0000_0000_0000;   // canonical nan
	localparam fpmul_pkg::fp_word_t POS_ZERO = 64'h0000_0000_0000_0000;
	localparam fpmul_pkg::fp_word_t NEG_ZERO = 64'h8000_0000_0000_0000;
	// flag order is invalid, unimp, overflow, underflow, inexact
	localparam fpmul_pkg::fp_flags_t F_NONE = 5'b00000;
	localparam fpmul_pkg::fp_flags_t F_INEXACT = 5'b00001;
	localparam fpmul_pkg::fp_flags_t F_INVALID = 5'b10000;
	localparam fpmul_pkg::fp_flags_t F_UNIMP = 5'b01000;
	localparam fpmul_pkg::fp_flags_t F_OVF = 5'b00101;       // overflow with inexact
	localparam fpmul_pkg::fp_flags_t F_UNF = 5'b00011;       // underflow with inexact
	localparam fpmul_pkg::fp_flags_t ALL_BITS = 5'b11111;
	localparam fpmul_pkg::fp_flags_t NO_INEXACT = 5'b11110;

	logic CK;
	logic arst_n;
	logic in_valid;
	fpmul_pkg::fp_word_t op_a, op_b;
	logic out_valid;
	fpmul_pkg::fp_word_t result;
	fpmul_pkg::fp_flags_t flags;

	// directed table, one row per operation
	fpmul_pkg::fp_word_t tab_a [$];
	fpmul_pkg::fp_word_t tab_b [$];
	fpmul_pkg::fp_word_t tab_res [$];
	fpmul_pkg::fp_flags_t tab_flg [$];

	// operations in flight, oldest first
	fpmul_pkg::fp_word_t exp_res_q [$];
	fpmul_pkg::fp_flags_t exp_flg_q [$];
	fpmul_pkg::fp_flags_t exp_mask_q [$];
	int issue_q [$];        // cycle of each accepted in_valid

	int cyc = 0;
	int seed;

	fpmul_unit dut0 (.CK(CK), .arst_n(arst_n), .in_valid(in_valid), .op_a(op_a),
		.op_b(op_b), .out_valid(out_valid), .result(result), .flags(flags));

	initial
	begin
		CK = 1'b0;
		forever #10 CK = ~CK;
	end

	always @(posedge CK)
		cyc <= cyc + 1;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	// ieee product rounded to nearest even by the host
	function automatic fpmul_pkg::fp_word_t real_product(input fpmul_pkg::fp_word_t a, b);
		real_product = $realtobits($bitstoreal(a) * $bitstoreal(b));
	endfunction

	task automatic add_row(input fpmul_pkg::fp_word_t a, b, res, input fpmul_pkg::fp_flags_t flg);
		tab_a.push_back(a);
		tab_b.push_back(b);
		tab_res.push_back(res);
		tab_flg.push_back(flg);
	endtask

	task automatic build_table();
		add_row(64'h3FF8_0000_0000_0000, 64'h3FF8_0000_0000_0000, 64'h4002_0000_0000_0000,
			F_NONE);     // 1.5 * 1.5 = 2.25
		add_row(64'h3FB9_9999_9999_999A, 64'h3FD3_3333_3333_3333,
			real_product(64'h3FB9_9999_9999_999A, 64'h3FD3_3333_3333_3333), F_INEXACT);
		add_row(64'h4008_0000_0000_0000, 64'hC000_0000_0000_0000, 64'hC018_0000_0000_0000,
			F_NONE);     // 3 * -2
		add_row(64'h3FF0_0000_0000_0001, 64'h3FF0_0000_0000_0001,
			real_product(64'h3FF0_0000_0000_0001, 64'h3FF0_0000_0000_0001), F_INEXACT);
		add_row(64'h0010_0000_0000_0000, 64'h3FF0_0000_0000_0000, 64'h0010_0000_0000_0000,
			F_NONE);     // smallest normal stays normal
		add_row(64'h7FE0_0000_0000_0000, 64'h3FE0_0000_0000_0000, 64'h7FD0_0000_0000_0000,
			F_NONE);
		add_row(64'h4009_21FB_5444_2D18, 64'h4005_BF0A_8B14_5769,
			real_product(64'h4009_21FB_5444_2D18, 64'h4005_BF0A_8B14_5769), F_INEXACT);
		add_row(64'hC009_21FB_5444_2D18, 64'hC009_21FB_5444_2D18,
			real_product(64'hC009_21FB_5444_2D18, 64'hC009_21FB_5444_2D18), F_INEXACT);
		// zero operands, sign is the xor
		add_row(POS_ZERO, 64'h4008_0000_0000_0000, POS_ZERO, F_NONE);
		add_row(NEG_ZERO, 64'h4008_0000_0000_0000, NEG_ZERO, F_NONE);
		add_row(64'h3FF8_0000_0000_0000, NEG_ZERO, NEG_ZERO, F_NONE);
		add_row(64'hC000_0000_0000_0000, NEG_ZERO, POS_ZERO, F_NONE);
		add_row(POS_ZERO, POS_ZERO, POS_ZERO, F_NONE);
		// infinities
		add_row(POS_INF, 64'h4008_0000_0000_0000, POS_INF, F_NONE);
		add_row(NEG_INF, 64'h4008_0000_0000_0000, NEG_INF, F_NONE);
		add_row(POS_INF, NEG_INF, NEG_INF, F_NONE);
		add_row(POS_INF, POS_ZERO, QNAN, F_INVALID);
		add_row(NEG_ZERO, NEG_INF, QNAN, F_INVALID);
		// nan and denormal operands are not computed
		add_row(64'h7FF4_0000_0000_0000, 64'h3FF8_0000_0000_0000, QNAN, F_UNIMP);
		add_row(64'h3FF8_0000_0000_0000, 64'hFFF8_0000_0000_0000, QNAN, F_UNIMP);
		add_row(64'h000F_FFFF_FFFF_FFFF, 64'h3FF8_0000_0000_0000, QNAN, F_UNIMP);
		add_row(64'h8000_0000_0000_0001, POS_INF, QNAN, F_UNIMP);
		add_row(POS_ZERO, 64'h7FF8_0000_0000_0001, QNAN, F_UNIMP);
		// range limits
		add_row(64'h7FE0_0000_0000_0000, 64'h4000_0000_0000_0000, POS_INF, F_OVF);
		add_row(64'hFFE0_0000_0000_0000, 64'h4000_0000_0000_0000, NEG_INF, F_OVF);
		add_row(64'h7FEF_FFFF_FFFF_FFFF, 64'h3FF0_0000_0000_0001, POS_INF, F_OVF);
		add_row(64'h0010_0000_0000_0000, 64'h3FE0_0000_0000_0000, POS_ZERO, F_UNF);
		add_row(64'h8010_0000_0000_0000, 64'h3FE0_0000_0000_0000, NEG_ZERO, F_UNF);
		add_row(64'h0010_0000_0000_0000, 64'h0010_0000_0000_0000, POS_ZERO, F_UNF);
	endtask

	// random normal operand, product exponent lands between 623 and 1424
	task automatic make_random(output fpmul_pkg::fp_word_t w);
		logic [31:0] hi, lo;
		int e;
		hi = $random(seed);
		lo = $random(seed);
		e = 823 + ({$random(seed)} % 401);
		w = {hi[31], fpmul_pkg::exp_t'(e), hi[19:0], lo};
	endtask

	// drive one operation on the next rising edge and queue its expected output
	task automatic issue(input fpmul_pkg::fp_word_t a, b, res,
		input fpmul_pkg::fp_flags_t flg, mask);
		@(posedge CK);
		in_valid <= 1'b1;
		op_a <= a;
		op_b <= b;
		exp_res_q.push_back(res);
		exp_flg_q.push_back(flg);
		exp_mask_q.push_back(mask);
	endtask

	task automatic idle_cycle();
		@(posedge CK);
		in_valid <= 1'b0;
		op_a <= QNAN;       // junk on the bus must be ignored
	endtask

	task automatic check_quiet(input int n);
		repeat (n)
		begin
			@(negedge CK);
			assert (out_valid === 1'b0) else report_failure($sformatf(
				"Error at %0t: out_valid = %b, expected 0", $time, out_valid));
			assert (flags === 5'b00000) else report_failure($sformatf(
				"Error at %0t: flags = %b, expected 00000", $time, flags));
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_res_q.size() != 0 && n < DRAIN_LIMIT)
		begin
			@(posedge CK);
			n++;
		end
	endtask

	// outputs sampled on the falling edge, well after they settle
	always @(negedge CK)
	begin
		fpmul_pkg::fp_word_t e_res;
		fpmul_pkg::fp_flags_t e_flg, e_mask;
		int t_issue;
		if (in_valid === 1'b1)
			issue_q.push_back(cyc);
		if (out_valid === 1'b1)
		begin
			if (exp_res_q.size() == 0)
				report_failure($sformatf("out_valid pulsed at %0t with no operation in flight",
					$time));
			else
			begin
				e_res = exp_res_q.pop_front();
				e_flg = exp_flg_q.pop_front();
				e_mask = exp_mask_q.pop_front();
				t_issue = issue_q.pop_front();
				assert (cyc - t_issue == `FPM_LATENCY) else report_failure($sformatf(
					"Error at %0t: out_valid latency = %0d, expected %0d", $time,
					cyc - t_issue, `FPM_LATENCY));
				assert (result === e_res) else report_failure($sformatf(
					"Error at %0t: result = %h, expected %h", $time, result, e_res));
				assert ((flags & e_mask) === (e_flg & e_mask)) else report_failure($sformatf(
					"Error at %0t: flags = %b, expected %b", $time, flags & e_mask,
					e_flg & e_mask));
			end
		end
	end

	initial
	begin
		fpmul_pkg::fp_word_t ra, rb;
		int gap;
		seed = 98168;
		arst_n = 1'b0;
		in_valid = 1'b0;
		op_a = '0;
		op_b = '0;
		build_table();
		check_quiet(4);             // reset held for four cycles
		@(posedge CK);
		arst_n <= 1'b1;
		check_quiet(3);             // still quiet before the first input
		foreach (tab_a[i])
			issue(tab_a[i], tab_b[i], tab_res[i], tab_flg[i], ALL_BITS);   // back to back
		repeat (6) idle_cycle();
		for (int n = 0; n < N_RANDOM; n++)
		begin
			make_random(ra);
			make_random(rb);
			issue(ra, rb, real_product(ra, rb), F_NONE, NO_INEXACT);
			gap = {$random(seed)} % 4;
			if (gap == 0)
				idle_cycle();       // some idle cycles mixed into the stream
		end
		idle_cycle();
		wait_drain();
		repeat (3) idle_cycle();    // no stray pulse after the last result
		if (exp_res_q.size() != 0)
			report_failure($sformatf("timeout, %0d results never came out", exp_res_q.size()));
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* hw/fpmul_unit.sv */
//********************************************************************
// fixed 4 cycle latency, one operation per cycle, no back-pressure
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fpmul_params.svh"

module fpmul_unit (
	input  wire logic                 CK,
	input  wire logic                 arst_n,
	input  wire logic                 in_valid,
	input  wire fpmul_pkg::fp_word_t  op_a,
	input  wire fpmul_pkg::fp_word_t  op_b,
	output logic                      out_valid,
	output fpmul_pkg::fp_word_t       result,
	output fpmul_pkg::fp_flags_t      flags
);

	// stage 1 outputs, side-band goes straight to the last stage
	logic s1_valid, s1_sign, s1_special_nan, s1_special_inf, s1_special_zero;
	fpmul_pkg::sig_t s1_sig_x, s1_sig_y;
	fpmul_pkg::exp_sum_t s1_exp_sum;
	fpmul_pkg::fp_flags_t s1_flags;

	// stage 2, booth selects and multiples
	logic s2_valid;
	fpmul_pkg::booth_sel_t zerox, onex, twox, threex, fourx, neg;
	fpmul_pkg::sig_t s2_x;
	fpmul_pkg::mult3_t s2_x3;

	// stage 3, redundant product
	logic s3_valid;
	fpmul_pkg::red_t s3_sum, s3_carry;

	operand_classify u_classify (.CK(CK), .arst_n(arst_n), .in_valid(in_valid),
		.op_a(op_a), .op_b(op_b), .s1_valid(s1_valid), .s1_sign(s1_sign),
		.s1_special_nan(s1_special_nan), .s1_special_inf(s1_special_inf),
		.s1_special_zero(s1_special_zero), .s1_sig_x(s1_sig_x), .s1_sig_y(s1_sig_y),
		.s1_exp_sum(s1_exp_sum), .s1_flags(s1_flags));

	booth_recode u_booth (.CK(CK), .arst_n(arst_n), .s1_valid(s1_valid),
		.s1_sig_x(s1_sig_x), .s1_sig_y(s1_sig_y), .s2_valid(s2_valid),
		.zerox(zerox), .onex(onex), .twox(twox), .threex(threex), .fourx(fourx),
		.neg(neg), .s2_x(s2_x), .s2_x3(s2_x3));

	pp_array u_array (.CK(CK), .arst_n(arst_n), .s2_valid(s2_valid),
		.zerox(zerox), .onex(onex), .twox(twox), .threex(threex), .fourx(fourx),
		.neg(neg), .s2_x(s2_x), .s2_x3(s2_x3), .s3_valid(s3_valid),
		.s3_sum(s3_sum), .s3_carry(s3_carry));

	round_normalize u_round (.CK(CK), .arst_n(arst_n), .s3_valid(s3_valid),
		.s3_sum(s3_sum), .s3_carry(s3_carry), .s1_sign(s1_sign),
		.s1_exp_sum(s1_exp_sum), .s1_special_nan(s1_special_nan),
		.s1_special_inf(s1_special_inf), .s1_special_zero(s1_special_zero),
		.s1_flags(s1_flags), .out_valid(out_valid), .result(result), .flags(flags));

endmodule

`default_nettype wire

/* hw/round_normalize.sv */
//********************************************************************
// round to nearest even only, tiny results flush to signed zero
// result holds its last value between operations, flags read zero
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fpmul_params.svh"

module round_normalize (
	input  wire logic                  CK,
	input  wire logic                  arst_n,
	input  wire logic                  s3_valid,
	input  wire fpmul_pkg::red_t       s3_sum,
	input  wire fpmul_pkg::red_t       s3_carry,
	input  wire logic                  s1_sign,
	input  wire fpmul_pkg::exp_sum_t   s1_exp_sum,
	input  wire logic                  s1_special_nan,
	input  wire logic                  s1_special_inf,
	input  wire logic                  s1_special_zero,
	input  wire fpmul_pkg::fp_flags_t  s1_flags,
	output logic                       out_valid,
	output fpmul_pkg::fp_word_t        result,
	output fpmul_pkg::fp_flags_t       flags
);

	localparam int SB_DEPTH = `FPM_LATENCY - 2;    // s1 side-band waits for s3
	localparam int SIG_W = `FPM_FRAC_W + 1;
	localparam int PROD_W = 2 * SIG_W;             // 106 bit product
	localparam logic [`FPM_EXP_W:0] EXP_MAX = {1'b0, {`FPM_EXP_W{1'b1}}};
	localparam fpmul_pkg::exp_t EXP_ONES = '1;
	localparam fpmul_pkg::exp_t EXP_ZERO = '0;
	localparam fpmul_pkg::frac_t FRAC_ZERO = '0;
	localparam fpmul_pkg::frac_t FRAC_QNAN = {1'b1, {(`FPM_FRAC_W-1){1'b0}}};

	logic sb_sign [SB_DEPTH];
	fpmul_pkg::exp_sum_t sb_exp [SB_DEPTH];
	logic sb_nan [SB_DEPTH];
	logic sb_inf [SB_DEPTH];
	logic sb_zero [SB_DEPTH];
	fpmul_pkg::fp_flags_t sb_flags [SB_DEPTH];

	logic [PROD_W-1:0] prod, norm;
	fpmul_pkg::frac_t mant;
	logic guard, sticky, rnd_up, inexact;
	logic [SIG_W-1:0] rounded;      // msb is the rounding carry
	fpmul_pkg::exp_sum_t exp_r;
	logic ovf, unf;
	logic sign_o;
	fpmul_pkg::fp_word_t res_n;
	fpmul_pkg::fp_flags_t flags_n;

	always_ff @(posedge CK)
	begin
		sb_sign[0] <= s1_sign;
		sb_exp[0] <= s1_exp_sum;
		sb_nan[0] <= s1_special_nan;
		sb_inf[0] <= s1_special_inf;
		sb_zero[0] <= s1_special_zero;
		sb_flags[0] <= s1_flags;
		for (int k = 1; k < SB_DEPTH; k++)
		begin
			sb_sign[k] <= sb_sign[k-1];
			sb_exp[k] <= sb_exp[k-1];
			sb_nan[k] <= sb_nan[k-1];
			sb_inf[k] <= sb_inf[k-1];
			sb_zero[k] <= sb_zero[k-1];
			sb_flags[k] <= sb_flags[k-1];
		end
	end

	assign sign_o = sb_sign[SB_DEPTH-1];
	assign prod = s3_sum[PROD_W-1:0] + s3_carry[PROD_W-1:0];  // bits above 106 drop out

	// product in [1,4), put the leading one at bit 105
	assign norm = prod[PROD_W-1] ? prod : (prod << 1);
	assign mant = norm[PROD_W-2 -: `FPM_FRAC_W];
	assign guard = norm[PROD_W-2-`FPM_FRAC_W];
	assign sticky = |norm[PROD_W-3-`FPM_FRAC_W:0];
	assign rnd_up = guard & (sticky | mant[0]);        // ties go to even
	assign rounded = {1'b0, mant} + SIG_W'(rnd_up);    // all-ones wraps to zero fraction
	assign inexact = guard | sticky;

	assign exp_r = sb_exp[SB_DEPTH-1] + fpmul_pkg::exp_sum_t'(prod[PROD_W-1])
		+ fpmul_pkg::exp_sum_t'(rounded[SIG_W-1]);
	assign ovf = ~exp_r[`FPM_EXP_W+1] & (exp_r[`FPM_EXP_W:0] >= EXP_MAX);
	assign unf = exp_r[`FPM_EXP_W+1] | (exp_r == '0);     // no denormal output

	always_comb
	begin
		flags_n = sb_flags[SB_DEPTH-1];     // invalid and unimp from stage 1
		if (sb_nan[SB_DEPTH-1])
			res_n = {1'b0, EXP_ONES, FRAC_QNAN};     // canonical nan, sign clear
		else if (sb_inf[SB_DEPTH-1])
			res_n = {sign_o, EXP_ONES, FRAC_ZERO};
		else if (sb_zero[SB_DEPTH-1])
			res_n = {sign_o, EXP_ZERO, FRAC_ZERO};
		else if (ovf)
		begin
			res_n = {sign_o, EXP_ONES, FRAC_ZERO};
			flags_n[fpmul_pkg::FLG_OVERFLOW] = 1'b1;
			flags_n[fpmul_pkg::FLG_INEXACT] = 1'b1;
		end
		else if (unf)
		begin
			res_n = {sign_o, EXP_ZERO, FRAC_ZERO};   // flush
			flags_n[fpmul_pkg::FLG_UNDERFLOW] = 1'b1;
			flags_n[fpmul_pkg::FLG_INEXACT] = 1'b1;
		end
		else
		begin
			res_n = {sign_o, exp_r[`FPM_EXP_W-1:0], rounded[`FPM_FRAC_W-1:0]};
			flags_n[fpmul_pkg::FLG_INEXACT] = inexact;
		end
	end

	always_ff @(posedge CK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid <= 1'b0;
			flags <= '0;
		end
		else
		begin
			out_valid <= s3_valid;
			flags <= s3_valid ? flags_n : '0;     // idle cycles report nothing
		end
	end

	always_ff @(posedge CK)
	begin
		if (s3_valid)
			result <= res_n;
	end

	a_ovf_unf_excl: assert property (@(posedge CK) disable iff (!arst_n)
		out_valid |-> !(flags[fpmul_pkg::FLG_OVERFLOW] && flags[fpmul_pkg::FLG_UNDERFLOW]))
		else $error("overflow and underflow flagged together");

endmodule

`default_nettype wire

/* hw/pp_array.sv */
//********************************************************************
// linear chain of 3:2 rows, sum plus carry equals the product mod 2^112
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fpmul_params.svh"

module pp_array (
	input  wire logic                   CK,
	input  wire logic                   arst_n,
	input  wire logic                   s2_valid,
	input  wire fpmul_pkg::booth_sel_t  zerox,
	input  wire fpmul_pkg::booth_sel_t  onex,
	input  wire fpmul_pkg::booth_sel_t  twox,
	input  wire fpmul_pkg::booth_sel_t  threex,
	input  wire fpmul_pkg::booth_sel_t  fourx,
	input  wire fpmul_pkg::booth_sel_t  neg,
	input  wire fpmul_pkg::sig_t        s2_x,
	input  wire fpmul_pkg::mult3_t      s2_x3,
	output logic                        s3_valid,
	output fpmul_pkg::red_t             s3_sum,
	output fpmul_pkg::red_t             s3_carry
);

	localparam int DIGITS = `FPM_BOOTH_DIGITS;
	localparam int PP_W = `FPM_PP_W;
	localparam int RED_W = `FPM_RED_W;

	fpmul_pkg::pp_t pp [DIGITS];
	fpmul_pkg::red_t neg_row;       // +1 of each negated row, at bit 3i
	fpmul_pkg::red_t acc_s, acc_c, row, maj;

	// magnitude mux then ones complement on negative digits
	function automatic fpmul_pkg::pp_t booth_pp(input fpmul_pkg::sig_t x,
		input fpmul_pkg::mult3_t x3, input logic z, o, t, th, f, n);
		fpmul_pkg::pp_t mag;
		unique case (1'b1)
			z: mag = '0;
			o: mag = fpmul_pkg::pp_t'(x);
			t: mag = fpmul_pkg::pp_t'({x, 1'b0});
			th: mag = fpmul_pkg::pp_t'(x3);
			f: mag = fpmul_pkg::pp_t'({x, 2'b00});
			default: mag = '0;
		endcase
		booth_pp = n ? ~mag : mag;
	endfunction

	// sign extend one row to the full reduction width
	function automatic fpmul_pkg::red_t sext_pp(input fpmul_pkg::pp_t p);
		sext_pp = {{(RED_W-PP_W){p[PP_W-1]}}, p};
	endfunction

	always_comb
	begin
		neg_row = '0;
		for (int i = 0; i < DIGITS; i++)
		begin
			pp[i] = booth_pp(s2_x, s2_x3, zerox[i], onex[i], twox[i], threex[i],
				fourx[i], neg[i]);
			neg_row[3*i] = neg[i];
		end
	end

	always_comb
	begin
		acc_s = neg_row;            // neg bits ride in as the first row
		acc_c = sext_pp(pp[0]);
		row = '0;
		maj = '0;
		for (int i = 1; i < DIGITS; i++)
		begin
			row = sext_pp(pp[i]) << (3*i);      // radix-8 weight
			maj = (acc_s & acc_c) | (acc_s & row) | (acc_c & row);
			acc_s = acc_s ^ acc_c ^ row;
			acc_c = maj << 1;       // carries move one place up
		end
	end

	always_ff @(posedge CK or negedge arst_n)
	begin
		if (!arst_n)
			s3_valid <= 1'b0;
		else
			s3_valid <= s2_valid;
	end

	always_ff @(posedge CK)
	begin
		s3_sum <= acc_s;
		s3_carry <= acc_c;
	end

endmodule

`default_nettype wire

/* hw/booth_recode.sv */
//********************************************************************
// multiplier is unsigned, the zero pad on top keeps the last digit >= 0
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fpmul_params.svh"

module booth_recode (
	input  wire logic                CK,
	input  wire logic                arst_n,
	input  wire logic                s1_valid,
	input  wire fpmul_pkg::sig_t     s1_sig_x,
	input  wire fpmul_pkg::sig_t     s1_sig_y,
	output logic                     s2_valid,
	output fpmul_pkg::booth_sel_t    zerox,
	output fpmul_pkg::booth_sel_t    onex,
	output fpmul_pkg::booth_sel_t    twox,
	output fpmul_pkg::booth_sel_t    threex,
	output fpmul_pkg::booth_sel_t    fourx,
	output fpmul_pkg::booth_sel_t    neg,
	output fpmul_pkg::sig_t          s2_x,
	output fpmul_pkg::mult3_t        s2_x3
);

	localparam int DIGITS = `FPM_BOOTH_DIGITS;

	logic [3*DIGITS:0] ywin;        // {0, y, 0}, digit i reads bits 3i+3..3i
	fpmul_pkg::booth_sel_t z_n, o_n, t_n, th_n, f_n, n_n;
	fpmul_pkg::mult3_t x3;

	assign ywin = {1'b0, s1_sig_y, 1'b0};
	assign x3 = fpmul_pkg::mult3_t'({s1_sig_x, 1'b0}) + fpmul_pkg::mult3_t'(s1_sig_x);

	always_comb
	begin
		z_n = '0;
		o_n = '0;
		t_n = '0;
		th_n = '0;
		f_n = '0;
		for (int i = 0; i < DIGITS; i++)
		begin
			// digit = -4*w3 + 2*w2 + w1 + w0
			case (ywin[3*i +: 4])
				4'b0000, 4'b1111: z_n[i] = 1'b1;
				4'b0001, 4'b0010, 4'b1101, 4'b1110: o_n[i] = 1'b1;
				4'b0011, 4'b0100, 4'b1011, 4'b1100: t_n[i] = 1'b1;
				4'b0101, 4'b0110, 4'b1001, 4'b1010: th_n[i] = 1'b1;
				default: f_n[i] = 1'b1;     // 0111 and 1000
			endcase
			n_n[i] = ywin[3*i+3] & ~z_n[i];   // a zero digit stays positive
		end
	end

	always_ff @(posedge CK or negedge arst_n)
	begin
		if (!arst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge CK)
	begin
		zerox <= z_n;
		onex <= o_n;
		twox <= t_n;
		threex <= th_n;
		fourx <= f_n;
		neg <= n_n;
		s2_x <= s1_sig_x;
		s2_x3 <= x3;      // carry chain done here, off the array path
	end

	// the array mux relies on exactly one magnitude per digit
	for (genvar i = 0; i < DIGITS; i++)
	begin : g_sel_chk
		a_sel_onehot: assert property (@(posedge CK) disable iff (!arst_n)
			s2_valid |-> $onehot({zerox[i], onex[i], twox[i], threex[i], fourx[i]}))
			else $error("booth digit %0d select not one-hot", i);
	end

endmodule

`default_nettype wire

/* hw/operand_classify.sv */
//********************************************************************
// nan and denormal operands are not computed, they give unimp and a nan
// payload registers have no reset, only s1_valid is cleared
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fpmul_params.svh"

module operand_classify (
	input  wire logic                 CK,
	input  wire logic                 arst_n,
	input  wire logic                 in_valid,
	input  wire fpmul_pkg::fp_word_t  op_a,
	input  wire fpmul_pkg::fp_word_t  op_b,
	output logic                      s1_valid,
	output logic                      s1_sign,
	output logic                      s1_special_nan,
	output logic                      s1_special_inf,
	output logic                      s1_special_zero,
	output fpmul_pkg::sig_t           s1_sig_x,     // multiplicand
	output fpmul_pkg::sig_t           s1_sig_y,     // multiplier, goes to booth
	output fpmul_pkg::exp_sum_t       s1_exp_sum,
	output fpmul_pkg::fp_flags_t      s1_flags
);

	logic a_nan, a_inf, a_den, a_zero;
	logic b_nan, b_inf, b_den, b_zero;
	logic unimp, invalid;
	logic nan_res, inf_res, zero_res;
	fpmul_pkg::fp_flags_t flags_n;

	// {nan, inf, denormal, zero} from exponent and fraction checks
	function automatic logic [3:0] classify(input fpmul_pkg::fp_word_t w);
		fpmul_pkg::exp_t e;
		fpmul_pkg::frac_t f;
		e = w[`FPM_FRAC_W +: `FPM_EXP_W];
		f = w[`FPM_FRAC_W-1:0];
		classify = {(&e) & (|f), (&e) & ~(|f), ~(|e) & (|f), ~(|e) & ~(|f)};
	endfunction

	assign {a_nan, a_inf, a_den, a_zero} = classify(op_a);
	assign {b_nan, b_inf, b_den, b_zero} = classify(op_b);

	assign unimp = a_nan | a_den | b_nan | b_den;
	assign invalid = (a_inf & b_zero) | (b_inf & a_zero);

	// special results kept mutually exclusive, nan wins
	assign nan_res = unimp | invalid;
	assign inf_res = ~nan_res & (a_inf | b_inf);
	assign zero_res = ~nan_res & ~inf_res & (a_zero | b_zero);

	always_comb
	begin
		flags_n = '0;       // range flags are decided in the last stage
		flags_n[fpmul_pkg::FLG_INVALID] = invalid;
		flags_n[fpmul_pkg::FLG_UNIMP] = unimp;
	end

	always_ff @(posedge CK or negedge arst_n)
	begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge CK)
	begin
		s1_sign <= op_a[`FPM_FRAC_W+`FPM_EXP_W] ^ op_b[`FPM_FRAC_W+`FPM_EXP_W];
		s1_sig_x <= {1'b1, op_a[`FPM_FRAC_W-1:0]};     // hidden one
		s1_sig_y <= {1'b1, op_b[`FPM_FRAC_W-1:0]};
		// ea + eb - bias, two zero bits on top keep the borrow
		s1_exp_sum <= {2'b00, op_a[`FPM_FRAC_W +: `FPM_EXP_W]}
			+ {2'b00, op_b[`FPM_FRAC_W +: `FPM_EXP_W]}
			- (`FPM_EXP_W+2)'(`FPM_EXP_BIAS);
		s1_special_nan <= nan_res;
		s1_special_inf <= inf_res;
		s1_special_zero <= zero_res;
		s1_flags <= flags_n;
	end

endmodule

`default_nettype wire

/* hw/fpmul_pkg.sv */
//********************************************************************
// widths follow fpmul_params.svh, flag bit order matches the flags port
//********************************************************************
`default_nettype none

`include "fpmul_params.svh"

package fpmul_pkg;

	// packed binary64 word, sign on top
	typedef logic [`FPM_FRAC_W+`FPM_EXP_W:0] fp_word_t;

	typedef logic [`FPM_FRAC_W-1:0] frac_t;      // stored fraction
	typedef logic [`FPM_FRAC_W:0] sig_t;         // fraction with hidden one
	typedef logic [`FPM_EXP_W-1:0] exp_t;        // biased exponent field

	// exponent sum keeps two extra bits
	// msb set means the sum went below zero
	typedef logic signed [`FPM_EXP_W+1:0] exp_sum_t;

	typedef logic [`FPM_BOOTH_DIGITS-1:0] booth_sel_t; // one bit per digit
	typedef logic [`FPM_FRAC_W+2:0] mult3_t;     // 3x needs two more bits
	typedef logic [`FPM_PP_W-1:0] pp_t;          // one partial product row
	typedef logic [`FPM_RED_W-1:0] red_t;        // carry-save vector

	// exception flags, bit positions below
	typedef logic [4:0] fp_flags_t;

	localparam int FLG_INVALID = 4;      // inf times zero
	localparam int FLG_UNIMP = 3;        // nan or denormal operand
	localparam int FLG_OVERFLOW = 2;
	localparam int FLG_UNDERFLOW = 1;    // result flushed to zero
	localparam int FLG_INEXACT = 0;

endpackage

`default_nettype wire

/* include/fpmul_params.svh */
//********************************************************************
// double precision only, field widths are fixed by IEEE 754 binary64
// latency counts register stages from input sample to output pulse
//********************************************************************
`ifndef FPMUL_PARAMS_SVH
`define FPMUL_PARAMS_SVH

// operand fields
`define FPM_FRAC_W 52          // stored fraction bits
`define FPM_EXP_W 11           // biased exponent bits
`define FPM_EXP_BIAS 1023      // binary64 bias

// radix-8 multiplier array
// 53-bit significand plus a zero top bit gives 18 three-bit digits
`define FPM_BOOTH_DIGITS 18
`define FPM_PP_W 56            // 4x multiple plus sign
`define FPM_RED_W 112          // sum and carry vectors, product is 106 of these

// pipeline
`define FPM_LATENCY 4          // classify, recode, array, round

`endif
